/* list.f */
+incdir+src
src/mduPkg.sv
src/issueStage.sv
src/pipeMultiplier.sv
src/pipeDivider.sv
src/mduCore.sv
src/writebackStage.sv
src/mduTop.sv
verification/mduTb.sv

/* src/issueStage.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module issueStage (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  mduPkg::MduReq   req,
    output logic            reqReady,
    output logic            mulStart,
    output logic            divStart,
    output logic [31:0]     opA,
    output logic [31:0]     opB,
    output mduPkg::ArithTag tag
);
    // slot index of the HI writeback, counted in cycles from the accept edge
    localparam int MulHiSlot = `MDU_MUL_CYCLE + 1;
    localparam int DivHiSlot = `MDU_DIV_CYCLE + 1;

    logic [`MDU_SLOT_W-1:0] booked; // bit j set means the output cycle after edge now+j is taken
    logic [`MDU_SLOT_W-1:0] need;
    logic                   isMul;
    logic                   isDiv;
    logic                   isSigned;
    logic                   sgnA;
    logic                   sgnB;
    logic                   accept;

    assign isMul    = (req.op == mduPkg::MULT) || (req.op == mduPkg::MULTU);
    assign isDiv    = (req.op == mduPkg::DIV) || (req.op == mduPkg::DIVU);
    assign isSigned = (req.op == mduPkg::MULT) || (req.op == mduPkg::DIV);
    assign sgnA     = isSigned && req.rs0Data[31];
    assign sgnB     = isSigned && req.rs1Data[31];

    always_comb begin
        need = '0;
        if (isMul) begin
            need[MulHiSlot]     = 1'b1;
            need[MulHiSlot + 1] = 1'b1;
        end else if (isDiv) begin
            need[DivHiSlot]     = 1'b1;
            need[DivHiSlot + 1] = 1'b1;
        end
    end

    assign reqReady = (booked & need) == '0;
    assign accept   = reqValid && reqReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            booked   <= '0;
            mulStart <= 1'b0;
            divStart <= 1'b0;
        end else begin
            booked   <= (booked >> 1) | (accept ? (need >> 1) : '0); // window moves one cycle
            mulStart <= accept && isMul;
            divStart <= accept && isDiv;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opA           <= sgnA ? -req.rs0Data : req.rs0Data;
            opB           <= sgnB ? -req.rs1Data : req.rs1Data;
            tag.hiTag     <= req.hiTag;
            tag.loTag     <= req.loTag;
            tag.negFirst  <= sgnA ^ sgnB;
            tag.negSecond <= isDiv && sgnA; // remainder follows the dividend
        end
    end

    // a stalled request stays on the port until it is taken
    reqHeldWhileStalled: assert property (@(posedge clk) disable iff (rst)
        (reqValid && !reqReady) |=> (reqValid && $stable(req)));

endmodule

/* src/mduCore.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mduCore (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mulStart,
    input  logic                  divStart,
    input  logic [31:0]           opA,
    input  logic [31:0]           opB,
    input  mduPkg::ArithTag       tag,
    output logic                  mulDone,
    output logic                  divDone,
    output logic [31:0]           resHi,
    output logic [31:0]           resLo,
    output mduPkg::WbTag [1:0]    dstTag // [1] is the HI tag, [0] the LO tag
);
    localparam int MulDepth = `MDU_MUL_CYCLE;
    localparam int DivDepth = `MDU_DIV_CYCLE;

    logic [63:0]         prodU;
    logic [31:0]         quoU;
    logic [31:0]         remU;
    logic [63:0]         prod;
    logic [31:0]         quo;
    logic [31:0]         rem;
    logic [MulDepth-1:0] mulValid;
    logic [DivDepth-1:0] divValid;
    mduPkg::ArithTag     mulTagPipe [MulDepth];
    mduPkg::ArithTag     divTagPipe [DivDepth];
    mduPkg::ArithTag     mulTagOut;
    mduPkg::ArithTag     divTagOut;

    pipeMultiplier uMul (
        .clk (clk),
        .rst (rst),
        .a   (opA),
        .b   (opB),
        .p   (prodU)
    );

    pipeDivider uDiv (
        .clk       (clk),
        .rst       (rst),
        .dividend  (opA),
        .divisor   (opB),
        .quotient  (quoU),
        .remainder (remU)
    );

    ////////////////////////////////////////
    // side pipelines
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mulValid <= '0;
            divValid <= '0;
        end else begin
            mulValid <= {mulValid[MulDepth-2:0], mulStart};
            divValid <= {divValid[DivDepth-2:0], divStart};
        end
    end

    always_ff @(posedge clk) begin
        mulTagPipe[0] <= tag;
        for (int i = 1; i < MulDepth; i++) begin
            mulTagPipe[i] <= mulTagPipe[i-1];
        end
        divTagPipe[0] <= tag;
        for (int i = 1; i < DivDepth; i++) begin
            divTagPipe[i] <= divTagPipe[i-1];
        end
    end

    assign mulTagOut = mulTagPipe[MulDepth-1];
    assign divTagOut = divTagPipe[DivDepth-1];

    // sign restore wraps, so 0x8000_0000 stays as it is
    assign prod = mulTagOut.negFirst ? -prodU : prodU;
    assign quo  = divTagOut.negFirst ? -quoU : quoU;
    assign rem  = divTagOut.negSecond ? -remU : remU;

    assign mulDone = mulValid[MulDepth-1];
    assign divDone = divValid[DivDepth-1];

    always_comb begin
        if (mulDone) begin
            resHi     = prod[63:32];
            resLo     = prod[31:0];
            dstTag[1] = mulTagOut.hiTag;
            dstTag[0] = mulTagOut.loTag;
        end else begin
            resHi     = rem; // division reports the remainder on HI
            resLo     = quo;
            dstTag[1] = divTagOut.hiTag;
            dstTag[0] = divTagOut.loTag;
        end
    end

    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(mulDone && divDone));

endmodule

/* src/mduPkg.sv */
`include "mdu_macros.svh"

package mduPkg;

    typedef enum logic [2:0] {
        MDU_NOP = 3'd0,
        MULT    = 3'd1,
        MULTU   = 3'd2,
        DIV     = 3'd3,
        DIVU    = 3'd4
    } MduOp;

    // destination of one micro-op result
    typedef struct packed {
        logic [`MDU_PREG_W-1:0] rd;
        logic [`MDU_ROB_W-1:0]  id;
    } WbTag;

    typedef struct packed {
        MduOp        op;
        logic [31:0] rs0Data;
        logic [31:0] rs1Data;
        WbTag        hiTag;
        WbTag        loTag;
    } MduReq;

    // negFirst flips the product or the quotient, negSecond flips the remainder
    typedef struct packed {
        WbTag hiTag;
        WbTag loTag;
        logic negFirst;
        logic negSecond;
    } ArithTag;

    typedef struct packed {
        logic                   wen;
        logic [`MDU_PREG_W-1:0] rd;
        logic [31:0]            wdata;
    } PrfWrite;

    typedef struct packed {
        logic                  setFinish;
        logic [`MDU_ROB_W-1:0] id;
    } RobFinish;

    typedef enum logic [2:0] {
        WB_IDLE,
        WB_MUL_HI,
        WB_MUL_LO,
        WB_DIV_HI,
        WB_DIV_LO
    } WbState;

endpackage

/* src/mduTop.sv */
`timescale 1ns/1ps

module mduTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             reqValid,
    input  mduPkg::MduReq    req,
    output logic             reqReady,
    output mduPkg::PrfWrite  wb,
    output mduPkg::RobFinish finish
);
    logic               mulStart;
    logic               divStart;
    logic [31:0]        opA;
    logic [31:0]        opB;
    mduPkg::ArithTag    tag;
    logic               mulDone;
    logic               divDone;
    logic [31:0]        resHi;
    logic [31:0]        resLo;
    mduPkg::WbTag [1:0] dstTag;

    issueStage uIssue (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .mulStart (mulStart),
        .divStart (divStart),
        .opA      (opA),
        .opB      (opB),
        .tag      (tag)
    );

    mduCore uCore (
        .clk      (clk),
        .rst      (rst),
        .mulStart (mulStart),
        .divStart (divStart),
        .opA      (opA),
        .opB      (opB),
        .tag      (tag),
        .mulDone  (mulDone),
        .divDone  (divDone),
        .resHi    (resHi),
        .resLo    (resLo),
        .dstTag   (dstTag)
    );

    writebackStage uWb (
        .clk     (clk),
        .rst     (rst),
        .mulDone (mulDone),
        .divDone (divDone),
        .resHi   (resHi),
        .resLo   (resLo),
        .dstTag  (dstTag),
        .wb      (wb),
        .finish  (finish)
    );

endmodule

/* src/mdu_macros.svh */
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

////////////////////////////////////////
// pipeline latencies
////////////////////////////////////////

// each multiplier register stage accumulates one slice of the multiplier operand
`define MDU_MUL_CYCLE 4

// input register plus one restoring stage per quotient bit
`define MDU_DIV_CYCLE 33

////////////////////////////////////////
// widths
////////////////////////////////////////

`define MDU_PREG_W 6
`define MDU_ROB_W 5
`define MDU_SLOT_W (`MDU_DIV_CYCLE + 3) // covers the LO slot of the longest operation

`endif

/* src/pipeDivider.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module pipeDivider (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic [31:0] quotient,
    output logic [31:0] remainder
);
    localparam int Bits = `MDU_DIV_CYCLE - 1;

    // index 0 is the input register, index k+1 is the output of bit stage k
    logic [31:0] remQ [1:Bits];
    logic [31:0] dqQ  [Bits+1]; // dividend bits still to shift out, quotient bits shifting in
    logic [31:0] dvsQ [Bits];

    always_ff @(posedge clk) begin
        if (rst) begin
            dqQ[0]  <= '0;
            dvsQ[0] <= '0;
        end else begin
            dqQ[0]  <= dividend;
            dvsQ[0] <= divisor;
        end
    end

    ////////////////////////////////////////
    // restoring stages
    ////////////////////////////////////////

    for (genvar k = 0; k < Bits; k++) begin : gStage
        logic [32:0] cand;
        logic [32:0] diff;
        logic        qBit;

        if (k == 0) begin : gFirst
            assign cand = {32'h0, dqQ[k][31]}; // the partial remainder starts at zero
        end else begin : gNext
            assign cand = {remQ[k], dqQ[k][31]};
        end
        assign diff = cand - {1'b0, dvsQ[k]};
        assign qBit = ~diff[32]; // no borrow means the divisor fits

        always_ff @(posedge clk) begin
            if (rst) begin
                remQ[k+1] <= '0;
                dqQ[k+1]  <= '0;
            end else begin
                remQ[k+1] <= qBit ? diff[31:0] : cand[31:0];
                dqQ[k+1]  <= {dqQ[k][30:0], qBit};
            end
        end

        if (k < Bits - 1) begin : gCarry
            always_ff @(posedge clk) begin
                dvsQ[k+1] <= dvsQ[k];
            end
        end
    end

    assign quotient  = dqQ[Bits];
    assign remainder = remQ[Bits];

endmodule

/* src/pipeMultiplier.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module pipeMultiplier (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [63:0] p
);
    localparam int Stages = `MDU_MUL_CYCLE;
    localparam int Chunk  = 32 / Stages;

    logic [63:0] accQ    [Stages];
    logic [31:0] aQ      [Stages-1];
    logic [31:0] bQ      [Stages-1];
    logic [63:0] accIn   [Stages];
    logic [31:0] aIn     [Stages];
    logic [31:0] bIn     [Stages];
    logic [63:0] partial [Stages];

    // stage k adds a times the k-th slice of b, shifted into place
    always_comb begin
        for (int k = 0; k < Stages; k++) begin
            if (k == 0) begin
                accIn[k] = '0;
                aIn[k]   = a;
                bIn[k]   = b;
            end else begin
                accIn[k] = accQ[k-1];
                aIn[k]   = aQ[k-1];
                bIn[k]   = bQ[k-1];
            end
            partial[k] = (64'(aIn[k]) * 64'(bIn[k][k*Chunk +: Chunk])) << (k * Chunk);
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < Stages; k++) begin
            if (rst) begin
                accQ[k] <= '0;
            end else begin
                accQ[k] <= accIn[k] + partial[k];
            end
        end
        for (int k = 0; k < Stages - 1; k++) begin
            aQ[k] <= aIn[k];
            bQ[k] <= bIn[k];
        end
    end

    assign p = accQ[Stages-1];

endmodule

/* src/writebackStage.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module writebackStage (
    input  logic               clk,
    input  logic               rst,
    input  logic               mulDone,
    input  logic               divDone,
    input  logic [31:0]        resHi,
    input  logic [31:0]        resLo,
    input  mduPkg::WbTag [1:0] dstTag,
    output mduPkg::PrfWrite    wb,
    output mduPkg::RobFinish   finish
);
    mduPkg::WbState state;
    mduPkg::WbState nextState;
    logic [31:0]    loWord;
    mduPkg::WbTag   loTag;

    always_comb begin
        case (state)
            mduPkg::WB_MUL_HI: nextState = mduPkg::WB_MUL_LO;
            mduPkg::WB_DIV_HI: nextState = mduPkg::WB_DIV_LO;
            mduPkg::WB_IDLE,
            mduPkg::WB_MUL_LO,
            mduPkg::WB_DIV_LO: begin
                // a completion during LO chains straight into the next HI
                if (mulDone) begin
                    nextState = mduPkg::WB_MUL_HI;
                end else if (divDone) begin
                    nextState = mduPkg::WB_DIV_HI;
                end else begin
                    nextState = mduPkg::WB_IDLE;
                end
            end
            default: nextState = mduPkg::WB_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // registered writeback and finish
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= mduPkg::WB_IDLE;
            wb.wen           <= 1'b0;
            finish.setFinish <= 1'b0;
        end else begin
            state <= nextState;
            case (nextState)
                mduPkg::WB_MUL_HI,
                mduPkg::WB_DIV_HI: begin
                    wb.wen           <= 1'b1;
                    wb.rd            <= dstTag[1].rd;
                    wb.wdata         <= resHi;
                    finish.setFinish <= 1'b1;
                    finish.id        <= dstTag[1].id;
                    loWord           <= resLo; // held for the following cycle
                    loTag            <= dstTag[0];
                end
                mduPkg::WB_MUL_LO,
                mduPkg::WB_DIV_LO: begin
                    wb.wen           <= 1'b1;
                    wb.rd            <= loTag.rd;
                    wb.wdata         <= loWord;
                    finish.setFinish <= 1'b1;
                    finish.id        <= loTag.id;
                end
                default: begin
                    wb.wen           <= 1'b0;
                    finish.setFinish <= 1'b0;
                end
            endcase
        end
    end

    noDoneInHi: assert property (@(posedge clk) disable iff (rst)
        (state == mduPkg::WB_MUL_HI || state == mduPkg::WB_DIV_HI) |-> !(mulDone || divDone));

endmodule

/* verification/mduTb.sv */
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mduTb;
    localparam int NumRequests  = 300;
    localparam int ReadyTimeout = 100;
    localparam int DrainTimeout = 200;

    // one expected writeback, due in the cycle that follows edge number due
    typedef struct packed {
        int                     due;
        logic [`MDU_PREG_W-1:0] rd;
        logic [31:0]            data;
        logic [`MDU_ROB_W-1:0]  id;
    } ExpWb;

    logic                    clk;
    logic                    rst;
    logic                    reqValid;
    mduPkg::MduReq           req;
    logic                    reqReady;
    mduPkg::PrfWrite         wb;
    mduPkg::RobFinish        finish;

    ExpWb                    expQ[$];
    int                      edgeCount = 0;
    int                      errCount = 0;
    int                      checkCount = 0;
    int                      wbCount = 0;
    logic [31:0]             rngState;
    logic [`MDU_ROB_W-1:0]   idNext = '0;

    mduTop DUT (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .wb       (wb),
        .finish   (finish)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) edgeCount <= edgeCount + 1;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // corner values show up far more often than a uniform pick would give
    function automatic logic [31:0] pickOperand();
        logic [31:0] r;
        r = nextRand();
        case (r[31:29])
            3'd0: return 32'h0;
            3'd1: return 32'h1;
            3'd2: return 32'hFFFF_FFFF;
            3'd3: return 32'h8000_0000;
            3'd4: return nextRand() >> 20; // small magnitudes
            default: return nextRand();
        endcase
    endfunction

    function automatic mduPkg::MduReq buildReq(mduPkg::MduOp op, logic [31:0] a, logic [31:0] b);
        mduPkg::MduReq r;
        logic [31:0]   rnd;
        rnd = nextRand();
        r.op         = op;
        r.rs0Data    = a;
        r.rs1Data    = b;
        r.hiTag.rd   = rnd[31 -: `MDU_PREG_W];
        r.loTag.rd   = rnd[23 -: `MDU_PREG_W];
        r.hiTag.id   = idNext;
        r.loTag.id   = idNext + 1'b1;
        idNext       = idNext + 2'd2; // ids roll over the whole reorder buffer
        return r;
    endfunction

    function automatic mduPkg::MduReq randomReq();
        mduPkg::MduOp op;
        logic [31:0]  a;
        logic [31:0]  b;
        case (nextRand() >> 30)
            0: op = mduPkg::MULT;
            1: op = mduPkg::MULTU;
            2: op = mduPkg::DIV;
            default: op = mduPkg::DIVU;
        endcase
        a = pickOperand();
        b = pickOperand();
        if ((op == mduPkg::DIV || op == mduPkg::DIVU) && b == 32'h0) begin
            b = nextRand() | 32'h1;
        end
        return buildReq(op, a, b);
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // returns {HI, LO}; division truncates toward zero and the remainder keeps the dividend sign
    function automatic logic [63:0] modelResult(mduPkg::MduOp op, logic [31:0] a, logic [31:0] b);
        longint sa;
        longint sb;
        longint q;
        longint m;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            mduPkg::MULT: return 64'(sa * sb);
            mduPkg::MULTU: return {32'h0, a} * {32'h0, b};
            mduPkg::DIV: begin
                q = sa / sb; // done in 64 bits, so min / -1 wraps when truncated
                m = sa % sb;
                return {m[31:0], q[31:0]};
            end
            default: return {a % b, a / b};
        endcase
    endfunction

    function automatic int latencyOf(mduPkg::MduOp op);
        return (op == mduPkg::MULT || op == mduPkg::MULTU) ? `MDU_MUL_CYCLE : `MDU_DIV_CYCLE;
    endfunction

    function automatic bit slotsFree(int hiDue);
        foreach (expQ[i]) begin
            if (expQ[i].due == hiDue || expQ[i].due == hiDue + 1) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic checkField(string name, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("FAILED %s at cycle %0d: expected %h, got %h", name, edgeCount, exp, got);
        end
    endtask

    // called on a rising edge, returns on the edge that accepts the request
    task automatic issueReq(input mduPkg::MduReq r);
        int waited;
        waited = 0;
        reqValid <= 1'b1;
        req      <= r;
        @(negedge clk);
        while (reqReady !== 1'b1 && waited < ReadyTimeout) begin
            @(negedge clk);
            waited++;
        end
        assert (reqReady === 1'b1) else begin
            errCount++;
            $display("request was never accepted, reqReady stayed low for %0d cycles", waited);
        end
        @(posedge clk);
    endtask

    ////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////

    always @(negedge clk) begin : scoreboard
        int          hit;
        int          hiDue;
        logic [63:0] res;
        if (!rst) begin
            hit = -1;
            foreach (expQ[i]) begin
                if (expQ[i].due == edgeCount) hit = i;
            end
            if (hit >= 0) begin
                checkField("wb.wen", 32'(wb.wen), 32'h1);
                checkField("finish.setFinish", 32'(finish.setFinish), 32'h1);
                checkField("wb.rd", 32'(wb.rd), 32'(expQ[hit].rd));
                checkField("wb.wdata", wb.wdata, expQ[hit].data);
                checkField("finish.id", 32'(finish.id), 32'(expQ[hit].id));
                expQ.delete(hit);
                wbCount++;
            end else begin
                checkField("wb.wen", 32'(wb.wen), 32'h0); // nothing was queued for this cycle
                checkField("finish.setFinish", 32'(finish.setFinish), 32'h0);
            end
            if (reqValid) begin
                hiDue = edgeCount + latencyOf(req.op) + 2; // accept edge is the next one
                checkField("reqReady", 32'(reqReady), 32'(slotsFree(hiDue)));
                if (reqReady) begin
                    res = modelResult(req.op, req.rs0Data, req.rs1Data);
                    expQ.push_back('{hiDue, req.hiTag.rd, res[63:32], req.hiTag.id});
                    expQ.push_back('{hiDue + 1, req.loTag.rd, res[31:0], req.loTag.id});
                end
            end
        end
    end

    initial begin
        int waited;
        int gap;
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        rngState = 32'hd203_c88f;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkField("reqReady", 32'(reqReady), 32'h1);
        @(posedge clk);

        issueReq(buildReq(mduPkg::DIV, 32'h8000_0000, 32'hFFFF_FFFF));
        issueReq(buildReq(mduPkg::MULT, 32'h8000_0000, 32'h8000_0000));
        issueReq(buildReq(mduPkg::MULT, 32'hFFFF_FFFF, 32'h7FFF_FFFF)); // waits one slot pair
        issueReq(buildReq(mduPkg::DIV, 32'hFFFF_FFF9, 32'h0000_0002));
        for (int n = 0; n < NumRequests; n++) begin
            issueReq(randomReq());
            gap = (nextRand() >> 29);
            if (gap > 3) begin
                gap = 0; // back to back half of the time
            end
            if (gap > 0) begin
                reqValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        reqValid <= 1'b0;

        waited = 0;
        while (expQ.size() != 0 && waited < DrainTimeout) begin
            @(posedge clk);
            waited++;
        end
        assert (expQ.size() == 0) else begin
            errCount++;
            $display("%0d writebacks never arrived after the last request", expQ.size());
        end
        repeat (4) @(posedge clk);

        $display("checks %0d, writebacks %0d, errors %0d", checkCount, wbCount, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
